//--- bilinear_blend.sv
`default_nettype none

module bilinear_blend import clahe_pkg::*; (
	input  wire logic     clk,
	input  wire logic     reset_n,
	input  wire channel_t i_m,
	input  wire channel_t i_r,
	input  wire channel_t i_u,
	input  wire channel_t i_o,
	input  wire weight_t  i_weight_x,
	input  wire weight_t  i_weight_y,
	output channel_t      o_value
);

	weight_t              inv_wy;
	weight_t              inv_wx;
	logic [PROD_BITS-1:0] sum_a;
	logic [PROD_BITS-1:0] sum_b;
	logic [PROD_BITS-1:0] sum_out;
	channel_t             a_q;
	channel_t             b_q;
	weight_t              wx_q;
	logic [PROD_BITS-1:0] prod_a_q;
	logic [PROD_BITS-1:0] prod_b_q;

	// ----------------------------------------
	// vertical pass
	// ----------------------------------------
	assign inv_wy = WEIGHT_MAX - i_weight_y;
	// weights sum to 255, so the sum fits in 16 bits
	assign sum_a  = PROD_BITS'(i_m) * inv_wy + PROD_BITS'(i_u) * i_weight_y;
	assign sum_b  = PROD_BITS'(i_r) * inv_wy + PROD_BITS'(i_o) * i_weight_y;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			a_q  <= '0;
			b_q  <= '0;
			wx_q <= '0;
		end else begin
			a_q  <= sum_a[PROD_BITS-1:PIXEL_BITS];
			b_q  <= sum_b[PROD_BITS-1:PIXEL_BITS];
			// x weight follows the vertical result
			wx_q <= i_weight_x;
		end
	end

	// ----------------------------------------
	// horizontal pass
	// ----------------------------------------
	assign inv_wx = WEIGHT_MAX - wx_q;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			prod_a_q <= '0;
			prod_b_q <= '0;
		end else begin
			prod_a_q <= PROD_BITS'(a_q) * inv_wx;
			prod_b_q <= PROD_BITS'(b_q) * wx_q;
		end
	end

	// truncated sum, registered at the top level
	assign sum_out = prod_a_q + prod_b_q;
	assign o_value = sum_out[PROD_BITS-1:PIXEL_BITS];

endmodule

`default_nettype wire

//--- cfg_loader.sv
`default_nettype none

module cfg_loader import clahe_pkg::*; (
	input  wire logic                     clk,
	input  wire logic                     reset_n,
	input  wire logic                     i_cfg_req,
	input  wire logic [1:0]               i_cfg_sel,
	input  wire lut_addr_t                i_cfg_addr,
	input  wire channel_t                 i_cfg_data,
	output logic                          o_cfg_ack,
	output logic [NUM_CHANNELS-1:0]       o_wr_en,
	output lut_addr_t                     o_wr_addr,
	output channel_t                      o_wr_data
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_ACK,
		ST_WAIT_LOW
	} state_t;

	state_t     state;
	state_t     state_next;
	logic [1:0] sel_q;
	logic       wr_phase;

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE:     if (i_cfg_req) state_next = ST_WRITE;
			ST_WRITE:    state_next = ST_ACK;
			// host may already have dropped req
			ST_ACK:      state_next = i_cfg_req ? ST_WAIT_LOW : ST_IDLE;
			ST_WAIT_LOW: if (!i_cfg_req) state_next = ST_IDLE;
			default:     state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// request fields latched once per handshake
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && i_cfg_req) begin
			sel_q     <= i_cfg_sel;
			o_wr_addr <= i_cfg_addr;
			o_wr_data <= i_cfg_data;
		end
	end

	// ----------------------------------------
	// strobe decode and ack
	// ----------------------------------------
	assign wr_phase         = (state == ST_WRITE);
	assign o_wr_en[CHAN_R]  = wr_phase && (sel_q == CHAN_R);
	assign o_wr_en[CHAN_G]  = wr_phase && (sel_q == CHAN_G);
	assign o_wr_en[CHAN_B]  = wr_phase && (sel_q == CHAN_B);

	assign o_cfg_ack = (state == ST_ACK) || (state == ST_WAIT_LOW);

endmodule

`default_nettype wire

//--- clahe_asserts.sv
`default_nettype none

module clahe_asserts import clahe_pkg::*; (
	input wire logic                    clk,
	input wire logic                    reset_n,
	input wire logic                    i_cfg_req,
	input wire logic                    o_cfg_ack,
	input wire logic [NUM_CHANNELS-1:0] o_wr_en
);

	timeunit 1ns;
	timeprecision 1ps;

	// no ack and no strobe while in reset
	ack_idle_in_reset: assert property (@(posedge clk)
		!reset_n |-> (!o_cfg_ack && o_wr_en == '0))
		else $error("o_cfg_ack or write strobe active during reset");

	// ack answers a pending request
	ack_rise_with_req: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(o_cfg_ack) |-> i_cfg_req)
		else $error("o_cfg_ack rose without i_cfg_req high");

	// ack released once the host let go of req
	ack_fall_after_req: assert property (@(posedge clk) disable iff (!reset_n)
		$fell(o_cfg_ack) |-> $past(!i_cfg_req))
		else $error("o_cfg_ack fell while i_cfg_req was still high");

	strobe_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
		(|o_wr_en) |=> !(|o_wr_en))
		else $error("table write strobe longer than one cycle");

endmodule

bind cfg_loader clahe_asserts u_asserts (.*);

`default_nettype wire

//--- clahe_pkg.sv
`default_nettype none

package clahe_pkg;

	// ----------------------------------------
	// frame and tile geometry
	// ----------------------------------------
	localparam int FRAME_WIDTH   = 64;
	localparam int FRAME_HEIGHT  = 32;
	localparam int TILES_X       = 4;
	localparam int TILES_Y       = 4;
	localparam int TILE_WIDTH    = FRAME_WIDTH / TILES_X;
	localparam int TILE_HEIGHT   = FRAME_HEIGHT / TILES_Y;

	// in-tile offset to 8-bit weight
	localparam int TILE_X_SHIFT  = 4;
	localparam int TILE_Y_SHIFT  = 5;

	// counter and label widths
	localparam int COL_BITS      = $clog2(FRAME_WIDTH);
	localparam int ROW_BITS      = $clog2(FRAME_HEIGHT);
	localparam int TILE_COL_BITS = $clog2(TILE_WIDTH);
	localparam int TILE_ROW_BITS = $clog2(TILE_HEIGHT);
	localparam int TILE_IDX_BITS = $clog2(TILES_X);

	// ----------------------------------------
	// pixel, table and pipeline
	// ----------------------------------------
	localparam int PIXEL_BITS    = 8;
	localparam int NUM_CHANNELS  = 3;
	localparam int PROD_BITS     = 2 * PIXEL_BITS;
	localparam int LUT_ADDR_BITS = 2 * TILE_IDX_BITS + PIXEL_BITS;
	localparam int PIPE_LATENCY  = 6;

	// table select codes, code 3 writes nothing
	localparam logic [1:0] CHAN_R = 2'd0;
	localparam logic [1:0] CHAN_G = 2'd1;
	localparam logic [1:0] CHAN_B = 2'd2;

	typedef logic [PIXEL_BITS-1:0]    channel_t;
	typedef logic [7:0]               weight_t;
	typedef logic [TILE_IDX_BITS-1:0] tile_idx_t;
	typedef logic [LUT_ADDR_BITS-1:0] lut_addr_t;

	// all of the far neighbour
	localparam weight_t WEIGHT_MAX = 8'd255;

	typedef struct packed {
		logic vsync;
		logic de;
		logic hsync;
	} sync_t;

endpackage

`default_nettype wire

//--- clahe_top.sv
`default_nettype none

module clahe_top import clahe_pkg::*; (
	input  wire logic                               clk,
	input  wire logic                               reset_n,
	input  wire sync_t                              i_video_sync,
	input  wire logic [NUM_CHANNELS*PIXEL_BITS-1:0] i_data,
	input  wire logic                               i_cfg_req,
	input  wire logic [1:0]                         i_cfg_sel,
	input  wire lut_addr_t                          i_cfg_addr,
	input  wire channel_t                           i_cfg_data,
	output logic                                    o_cfg_ack,
	output sync_t                                   o_video_sync,
	output logic [NUM_CHANNELS*PIXEL_BITS-1:0]      o_data
);

	logic [NUM_CHANNELS*PIXEL_BITS-1:0] data_q;
	logic [NUM_CHANNELS*PIXEL_BITS-1:0] colour_d;
	logic [NUM_CHANNELS*PIXEL_BITS-1:0] out_q;
	tile_idx_t                          tile_x;
	tile_idx_t                          tile_y;
	weight_t                            weight_x;
	weight_t                            weight_y;
	weight_t                            weight_x_d;
	weight_t                            weight_y_d;
	logic [NUM_CHANNELS-1:0]            wr_en;
	lut_addr_t                          wr_addr;
	channel_t                           wr_data;
	sync_t                              sync_out;
	channel_t                           blend_value [NUM_CHANNELS];

	// cycle 1, input register
	always_ff @(posedge clk) begin
		data_q <= i_data;
	end

	// ----------------------------------------
	// position and table writes
	// ----------------------------------------
	pixel_locator u_locator (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_sync     (i_video_sync),
		.o_tile_x   (tile_x),
		.o_tile_y   (tile_y),
		.o_weight_x (weight_x),
		.o_weight_y (weight_y)
	);

	cfg_loader u_cfg_loader (
		.clk        (clk),
		.reset_n    (reset_n),
		.i_cfg_req  (i_cfg_req),
		.i_cfg_sel  (i_cfg_sel),
		.i_cfg_addr (i_cfg_addr),
		.i_cfg_data (i_cfg_data),
		.o_cfg_ack  (o_cfg_ack),
		.o_wr_en    (wr_en),
		.o_wr_addr  (wr_addr),
		.o_wr_data  (wr_data)
	);

	// colours meet the tile labels at cycle 2
	delay_line #(.T(logic [NUM_CHANNELS*PIXEL_BITS-1:0]), .DEPTH(1)) u_colour_dly (
		.clk (clk), .reset_n (reset_n), .i_data (data_q), .o_data (colour_d)
	);

	// weights meet the table outputs at cycle 3
	delay_line #(.T(weight_t), .DEPTH(1)) u_wx_dly (
		.clk (clk), .reset_n (reset_n), .i_data (weight_x), .o_data (weight_x_d)
	);

	delay_line #(.T(weight_t), .DEPTH(1)) u_wy_dly (
		.clk (clk), .reset_n (reset_n), .i_data (weight_y), .o_data (weight_y_d)
	);

	delay_line #(.T(sync_t), .DEPTH(PIPE_LATENCY)) u_sync_dly (
		.clk (clk), .reset_n (reset_n), .i_data (i_video_sync), .o_data (sync_out)
	);

	// ----------------------------------------
	// per channel tables and blend
	// ----------------------------------------
	for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_chan
		channel_t pix;
		channel_t lut_m;
		channel_t lut_r;
		channel_t lut_u;
		channel_t lut_o;

		// R sits in the top byte
		assign pix = colour_d[(NUM_CHANNELS-1-c)*PIXEL_BITS +: PIXEL_BITS];

		tile_lut_bank u_bank (
			.clk       (clk),
			.i_wr_en   (wr_en[c]),
			.i_wr_addr (wr_addr),
			.i_wr_data (wr_data),
			.i_tile_x  (tile_x),
			.i_tile_y  (tile_y),
			.i_value   (pix),
			.o_m       (lut_m),
			.o_r       (lut_r),
			.o_u       (lut_u),
			.o_o       (lut_o)
		);

		bilinear_blend u_blend (
			.clk        (clk),
			.reset_n    (reset_n),
			.i_m        (lut_m),
			.i_r        (lut_r),
			.i_u        (lut_u),
			.i_o        (lut_o),
			.i_weight_x (weight_x_d),
			.i_weight_y (weight_y_d),
			.o_value    (blend_value[c])
		);
	end

	// cycle 6, output register
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			out_q <= '0;
		end else begin
			out_q <= {blend_value[CHAN_R], blend_value[CHAN_G], blend_value[CHAN_B]};
		end
	end

	assign o_video_sync = sync_out;
	// blanked outside active video
	assign o_data       = sync_out.de ? out_q : '0;

endmodule

`default_nettype wire

//--- delay_line.sv
`default_nettype none

module delay_line #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 1
) (
	input  wire logic clk,
	input  wire logic reset_n,
	input  wire T     i_data,
	output T          o_data
);

	T stage [DEPTH];

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= i_data;
			// shift toward the tap
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1];
			end
		end
	end

	assign o_data = stage[DEPTH-1];

endmodule

`default_nettype wire

//--- files.f
clahe_pkg.sv
delay_line.sv
pixel_locator.sv
cfg_loader.sv
tile_lut_bank.sv
bilinear_blend.sv
clahe_top.sv
clahe_asserts.sv
tb_clahe.sv

//--- pixel_locator.sv
`default_nettype none

module pixel_locator import clahe_pkg::*; (
	input  wire logic  clk,
	input  wire logic  reset_n,
	input  wire sync_t i_sync,
	output tile_idx_t  o_tile_x,
	output tile_idx_t  o_tile_y,
	output weight_t    o_weight_x,
	output weight_t    o_weight_y
);

	logic                vsync_q;
	logic                vsync_prev;
	logic                de_q;
	logic                de_prev;
	logic                vsync_rise;
	logic                de_fall;
	logic [COL_BITS-1:0] col_cnt;
	logic [ROW_BITS-1:0] row_cnt;

	// ----------------------------------------
	// sync capture and edge detect
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			vsync_q    <= 1'b0;
			vsync_prev <= 1'b0;
			de_q       <= 1'b0;
			de_prev    <= 1'b0;
		end else begin
			vsync_q    <= i_sync.vsync;
			vsync_prev <= vsync_q;
			de_q       <= i_sync.de;
			de_prev    <= de_q;
		end
	end

	assign vsync_rise = vsync_q & ~vsync_prev;
	assign de_fall    = de_prev & ~de_q;

	// counters hold the position of the pixel now in de_q
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			row_cnt <= '0;
			col_cnt <= '0;
		end else if (vsync_rise) begin
			row_cnt <= '0;
			col_cnt <= '0;
		end else if (de_fall) begin
			row_cnt <= row_cnt + 1'b1;
			col_cnt <= '0;
		end else if (de_q) begin
			col_cnt <= col_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// tile labels and in-tile weights
	// ----------------------------------------
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_tile_x   <= '0;
			o_tile_y   <= '0;
			o_weight_x <= '0;
			o_weight_y <= '0;
		end else begin
			o_tile_x   <= tile_idx_t'(col_cnt >> TILE_COL_BITS);
			o_tile_y   <= tile_idx_t'(row_cnt >> TILE_ROW_BITS);
			// tile sizes are powers of two, offset is the low bits
			o_weight_x <= weight_t'(col_cnt[TILE_COL_BITS-1:0]) << TILE_X_SHIFT;
			o_weight_y <= weight_t'(row_cnt[TILE_ROW_BITS-1:0]) << TILE_Y_SHIFT;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_clahe -f files.f \
	|| { echo "build failed"; exit 1; }
./obj_dir/Vtb_clahe > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tb_clahe.sv
`default_nettype none

module tb_clahe import clahe_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_TESTS     = 5;
	localparam int ACK_TIMEOUT   = 20;
	localparam int PIXEL_TIMEOUT = 100;
	localparam int SEL3_WRITES   = 32;
	localparam int FRAME_PIXELS  = FRAME_WIDTH * FRAME_HEIGHT;

	typedef logic [NUM_CHANNELS*PIXEL_BITS-1:0] rgb_t;
	typedef enum logic [1:0] {FILL_IDENTITY, FILL_TILE_CONST, FILL_RANDOM} fill_t;
	typedef enum logic [1:0] {SRC_CONST, SRC_RAMP, SRC_RANDOM} src_t;

	typedef struct packed {
		fill_t    fill;
		src_t     src;
		channel_t level;
		logic     sel3_writes;
	} test_t;

	// table fill, pixel source, constant level, extra select-3 writes
	localparam test_t TESTS [NUM_TESTS] = '{
		'{FILL_IDENTITY,   SRC_CONST,  8'hc8, 1'b0},
		'{FILL_IDENTITY,   SRC_RAMP,   8'h00, 1'b0},
		'{FILL_TILE_CONST, SRC_RAMP,   8'h00, 1'b0},
		'{FILL_RANDOM,     SRC_RANDOM, 8'h00, 1'b0},
		'{FILL_IDENTITY,   SRC_RAMP,   8'h00, 1'b1}
	};

	logic      clk;
	logic      reset_n;
	sync_t     video_sync;
	rgb_t      video_data;
	logic      cfg_req;
	logic [1:0] cfg_sel;
	lut_addr_t cfg_addr;
	channel_t  cfg_data;
	logic      cfg_ack;
	sync_t     out_sync;
	rgb_t      out_data;

	integer    seed;
	int        error_count;
	int        check_count;
	int        req_count;
	logic      timeout_seen;
	int        ack_rises   = 0;
	int        vsync_rises = 0;
	int        de_falls    = 0;
	int        bad_lines   = 0;
	int        lut_model [NUM_CHANNELS][1 << LUT_ADDR_BITS];
	rgb_t      exp_q [$];

	clahe_top i_dut (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_video_sync (video_sync),
		.i_data       (video_data),
		.i_cfg_req    (cfg_req),
		.i_cfg_sel    (cfg_sel),
		.i_cfg_addr   (cfg_addr),
		.i_cfg_data   (cfg_data),
		.o_cfg_ack    (cfg_ack),
		.o_video_sync (out_sync),
		.o_data       (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// output sync and ack edges sampled mid cycle
	initial begin : monitor
		sync_t prev_sync;
		logic  prev_ack;
		int    line_pixels;
		sync_t sync_hist [$];
		sync_t delayed_sync;
		prev_sync   = '0;
		prev_ack    = 1'b0;
		line_pixels = 0;
		forever begin
			@(negedge clk);
			// output sync is the input sync of PIPE_LATENCY cycles earlier
			sync_hist.push_back(video_sync);
			if (sync_hist.size() > PIPE_LATENCY) begin
				delayed_sync = sync_hist.pop_front();
				check_value("o_video_sync", int'(out_sync), int'(delayed_sync));
			end
			if (out_sync.vsync && !prev_sync.vsync) vsync_rises++;
			if (cfg_ack && !prev_ack) ack_rises++;
			if (!out_sync.de && prev_sync.de) begin
				de_falls++;
				if (line_pixels != FRAME_WIDTH) bad_lines++;
				line_pixels = 0;
			end
			if (out_sync.de) line_pixels++;
			prev_sync = out_sync;
			prev_ack  = cfg_ack;
		end
	end

	task automatic check_value(input string name, input int got, input int expected);
		check_count++;
		if (got != expected) begin
			error_count++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, expected, $time);
		end
	endtask

	// ----------------------------------------
	// table writes over req/ack
	// ----------------------------------------
	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (cfg_ack !== level && cycles < ACK_TIMEOUT);
		if (cfg_ack !== level) begin
			$display("timeout: o_cfg_ack did not go to %0d within %0d cycles", level, ACK_TIMEOUT);
			timeout_seen = 1'b1;
		end
	endtask

	task automatic write_entry(input logic [1:0] sel, input lut_addr_t addr,
			input channel_t value);
		@(posedge clk);
		cfg_sel  <= sel;
		cfg_addr <= addr;
		cfg_data <= value;
		cfg_req  <= 1'b1;
		req_count++;
		wait_ack(1'b1);
		if (!timeout_seen) begin
			@(posedge clk);
			cfg_req <= 1'b0;
			wait_ack(1'b0);
		end
		// code 3 selects no table
		if (sel != 2'd3) lut_model[sel][addr] = int'(value);
	endtask

	task automatic load_tables(input fill_t fill);
		int       tile;
		channel_t value;
		for (int c = 0; c < NUM_CHANNELS; c++) begin
			for (int addr = 0; addr < (1 << LUT_ADDR_BITS); addr++) begin
				// tile y and tile x above the pixel value give ty * 4 + tx
				tile = addr >> PIXEL_BITS;
				case (fill)
					FILL_IDENTITY:   value = channel_t'(addr % 256);
					FILL_TILE_CONST: value = channel_t'(16 * tile);
					default:         value = channel_t'($random(seed));
				endcase
				write_entry(2'(c), lut_addr_t'(addr), value);
				if (timeout_seen) return;
			end
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic int lut_entry(int chan, int ty, int tx, int v);
		return lut_model[chan][(ty * TILES_X + tx) * 256 + v];
	endfunction

	function automatic channel_t expected_value(int chan, int row, int col, int v);
		int tx;
		int ty;
		int tx1;
		int ty1;
		int wx;
		int wy;
		int m;
		int r;
		int u;
		int o;
		int a;
		int b;
		tx  = col / TILE_WIDTH;
		ty  = row / TILE_HEIGHT;
		tx1 = (tx + 1) % TILES_X;
		ty1 = (ty + 1) % TILES_Y;
		wx  = (col % TILE_WIDTH) << TILE_X_SHIFT;
		wy  = (row % TILE_HEIGHT) << TILE_Y_SHIFT;
		m   = lut_entry(chan, ty, tx, v);
		r   = lut_entry(chan, ty, tx1, v);
		u   = lut_entry(chan, ty1, tx, v);
		o   = lut_entry(chan, ty1, tx1, v);
		// each pass keeps bits 15..8
		a   = ((m * (255 - wy) + u * wy) >> 8) & 255;
		b   = ((r * (255 - wy) + o * wy) >> 8) & 255;
		return channel_t'(((a * (255 - wx) + b * wx) >> 8) & 255);
	endfunction

	function automatic rgb_t make_pixel(test_t t, int row, int col);
		case (t.src)
			SRC_CONST: return {t.level, t.level + 8'd40, t.level + 8'd80};
			SRC_RAMP:  return {8'(col * 4 + row), 8'(row * 8), 8'(255 - col * 4)};
			default:   return rgb_t'($random(seed));
		endcase
	endfunction

	// ----------------------------------------
	// video frame
	// ----------------------------------------
	task automatic drive_cycle(input logic vs, input logic de, input logic hs, input rgb_t pixel);
		@(posedge clk);
		video_sync.vsync <= vs;
		video_sync.de    <= de;
		video_sync.hsync <= hs;
		video_data       <= pixel;
	endtask

	task automatic drive_frame(input test_t t);
		rgb_t pixel;
		rgb_t expected;
		repeat (2) drive_cycle(1'b1, 1'b0, 1'b0, '0);
		repeat (4) drive_cycle(1'b0, 1'b0, 1'b0, '0);
		for (int row = 0; row < FRAME_HEIGHT; row++) begin
			for (int col = 0; col < FRAME_WIDTH; col++) begin
				pixel    = make_pixel(t, row, col);
				expected = {expected_value(int'(CHAN_R), row, col, int'(pixel[23:16])),
					expected_value(int'(CHAN_G), row, col, int'(pixel[15:8])),
					expected_value(int'(CHAN_B), row, col, int'(pixel[7:0]))};
				exp_q.push_back(expected);
				drive_cycle(1'b0, 1'b1, 1'b0, pixel);
			end
			// line blanking with an hsync pulse
			repeat (2) drive_cycle(1'b0, 1'b0, 1'b1, '0);
			repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, '0);
		end
		repeat (PIPE_LATENCY + 4) drive_cycle(1'b0, 1'b0, 1'b0, '0);
	endtask

	task automatic collect_frame();
		int   cycles;
		rgb_t expected;
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			cycles = 0;
			do begin
				@(negedge clk);
				cycles++;
			end while (!out_sync.de && cycles < PIXEL_TIMEOUT);
			if (!out_sync.de) begin
				$display("timeout: output pixel %0d missing after %0d cycles", i, PIXEL_TIMEOUT);
				timeout_seen = 1'b1;
				return;
			end
			if (exp_q.size() == 0) begin
				$display("output pixel %0d has no input pixel to pair with", i);
				error_count++;
				return;
			end
			expected = exp_q.pop_front();
			check_value("o_data[23:16]", int'(out_data[23:16]), int'(expected[23:16]));
			check_value("o_data[15:8]", int'(out_data[15:8]), int'(expected[15:8]));
			check_value("o_data[7:0]", int'(out_data[7:0]), int'(expected[7:0]));
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin : main
		test_t t;
		fill_t fill;
		src_t  src;
		int    errors_before;
		int    vsync_before;
		int    falls_before;
		int    bad_before;
		seed         = 7;
		error_count  = 0;
		check_count  = 0;
		req_count    = 0;
		timeout_seen = 1'b0;
		reset_n      = 1'b0;
		video_sync   = '0;
		video_data   = '0;
		cfg_req      = 1'b0;
		cfg_sel      = '0;
		cfg_addr     = '0;
		cfg_data     = '0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;

		@(negedge clk);
		check_value("o_cfg_ack", int'(cfg_ack), 0);
		check_value("o_video_sync", int'(out_sync), 0);
		check_value("o_data", int'(out_data), 0);
		$display("test 0 reset: %0d mismatches", error_count);

		for (int i = 0; i < NUM_TESTS && !timeout_seen; i++) begin
			t             = TESTS[i];
			fill          = t.fill;
			src           = t.src;
			errors_before = error_count;
			load_tables(fill);
			if (t.sel3_writes) begin
				for (int k = 0; k < SEL3_WRITES && !timeout_seen; k++) begin
					write_entry(2'd3, lut_addr_t'($random(seed)), channel_t'($random(seed)));
				end
			end
			if (!timeout_seen) begin
				vsync_before = vsync_rises;
				falls_before = de_falls;
				bad_before   = bad_lines;
				fork
					drive_frame(t);
					collect_frame();
				join
				check_value("o_video_sync.vsync rises", vsync_rises - vsync_before, 1);
				check_value("o_video_sync.de falls", de_falls - falls_before, FRAME_HEIGHT);
				check_value("o_video_sync.de short lines", bad_lines - bad_before, 0);
				check_value("o_cfg_ack rises", ack_rises, req_count);
				exp_q.delete();
			end
			$display("test %0d %s/%s: %0d mismatches", i + 1, fill.name(), src.name(),
				error_count - errors_before);
		end

		$display("%0d checks, %0d errors, timeout %0d", check_count, error_count, timeout_seen);
		if (error_count == 0 && !timeout_seen) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tile_lut_bank.sv
`default_nettype none

module tile_lut_bank import clahe_pkg::*; (
	input  wire logic      clk,
	input  wire logic      i_wr_en,
	input  wire lut_addr_t i_wr_addr,
	input  wire channel_t  i_wr_data,
	input  wire tile_idx_t i_tile_x,
	input  wire tile_idx_t i_tile_y,
	input  wire channel_t  i_value,
	output channel_t       o_m,
	output channel_t       o_r,
	output channel_t       o_u,
	output channel_t       o_o
);

	// 16 tiles x 256 entries, tile y and x in the upper bits
	channel_t  mem [0:(1 << LUT_ADDR_BITS)-1];

	tile_idx_t tile_x_next;
	tile_idx_t tile_y_next;
	lut_addr_t addr_m;
	lut_addr_t addr_r;
	lut_addr_t addr_u;
	lut_addr_t addr_o;

	// neighbours wrap modulo 4 at the right and bottom edges
	assign tile_x_next = i_tile_x + tile_idx_t'(1);
	assign tile_y_next = i_tile_y + tile_idx_t'(1);

	assign addr_m = {i_tile_y,    i_tile_x,    i_value};
	assign addr_r = {i_tile_y,    tile_x_next, i_value};
	assign addr_u = {tile_y_next, i_tile_x,    i_value};
	assign addr_o = {tile_y_next, tile_x_next, i_value};

	// ----------------------------------------
	// write port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (i_wr_en) begin
			mem[i_wr_addr] <= i_wr_data;
		end
	end

	// ----------------------------------------
	// four read ports
	// ----------------------------------------
	// same-cycle read of a written entry sees the old value
	always_ff @(posedge clk) begin
		o_m <= mem[addr_m];
		o_r <= mem[addr_r];
		o_u <= mem[addr_u];
		o_o <= mem[addr_o];
	end

endmodule

`default_nettype wire
